/* hdl/frame_pkg.sv */
package frame_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stream payload
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int DATA_WIDTH = 8;  // byte-wide link

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // frame store and length limit
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // 64 beats of store, one extra pointer bit tells full from empty
  localparam int FIFO_ADDR_WIDTH = 6;

  // longest good frame in beats, kept below the store depth
  // so that a legal frame always fits into an empty FIFO
  localparam int MAX_FRAME_LEN = 48;

  // beat counter of the length check, must reach past MAX_FRAME_LEN
  localparam int LEN_WIDTH = 7;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // statistics
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int CNT_WIDTH = 16;  // saturating frame counters

endpackage

/* hdl/frame_len_check.sv */
`timescale 1ns/1ns

module frame_len_check (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [frame_pkg::DATA_WIDTH-1:0] up_tdata,
  input  logic                            up_tvalid,
  output logic                            up_tready,
  input  logic                            up_tlast,
  input  logic                            up_tuser,
  output logic [frame_pkg::DATA_WIDTH-1:0] chk_tdata,
  output logic                            chk_tvalid,
  input  logic                            chk_tready,
  output logic                            chk_tlast,
  output logic                            chk_tuser,
  output logic                            oversize
);

  logic [frame_pkg::LEN_WIDTH-1:0] beat_cnt;  // beats of this frame already taken
  logic                            too_long;
  logic                            len_bad;   // held beat ends an oversize frame
  logic                            up_accept;

  // register empty, or emptied on this edge
  assign up_tready = ~chk_tvalid | chk_tready;
  assign up_accept = up_tvalid & up_tready;

  // the incoming beat is number beat_cnt+1
  assign too_long = beat_cnt >= frame_pkg::MAX_FRAME_LEN;

  assign oversize = chk_tvalid & chk_tready & len_bad;

  always_ff @(posedge clk) begin
    if (rst) begin
      chk_tvalid <= 1'b0;
      beat_cnt   <= '0;
    end else begin
      if (up_tready) begin
        chk_tvalid <= up_tvalid;
      end
      if (up_accept) begin
        if (up_tlast) begin
          beat_cnt <= '0;
        end else if (beat_cnt != '1) begin  // saturate, long frames stay bad
          beat_cnt <= beat_cnt + 1'b1;
        end
      end
    end
  end

  // payload register
  always_ff @(posedge clk) begin
    if (up_accept) begin
      chk_tdata <= up_tdata;
      chk_tlast <= up_tlast;
      chk_tuser <= up_tlast & (up_tuser | too_long);
      len_bad   <= up_tlast & too_long;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  chk_hold_stable : assert property (
    @(posedge clk) disable iff (rst)
    chk_tvalid && !chk_tready |=> $stable(chk_tdata) && $stable(chk_tlast)
  );

endmodule

/* hdl/axis_frame_fifo.sv */
`timescale 1ns/1ns

module axis_frame_fifo #(
  parameter int ADDR_WIDTH = 6
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [frame_pkg::DATA_WIDTH-1:0] chk_tdata,
  input  logic                            chk_tvalid,
  output logic                            chk_tready,
  input  logic                            chk_tlast,
  input  logic                            chk_tuser,
  output logic [frame_pkg::DATA_WIDTH-1:0] dn_tdata,
  output logic                            dn_tvalid,
  input  logic                            dn_tready,
  output logic                            dn_tlast,
  output logic                            frame_dropped
);

  logic [ADDR_WIDTH:0] wr_ptr;      // committed, end of last good frame
  logic [ADDR_WIDTH:0] wr_ptr_cur;  // tentative, inside the frame being written
  logic [ADDR_WIDTH:0] rd_ptr;
  logic [ADDR_WIDTH:0] fill_level;

  logic [frame_pkg::DATA_WIDTH:0] mem [2**ADDR_WIDTH];  // {tlast, tdata}

  logic drop_frame;  // rest of the current frame is swallowed
  logic full_cur;
  logic empty;
  logic mem_we;
  logic rd_en;

  // input side never stalls, overflow is handled by dropping
  assign chk_tready = 1'b1;

  // next tentative write would land on a beat not yet read out
  assign full_cur = (wr_ptr_cur[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                    (wr_ptr_cur[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);

  assign empty      = wr_ptr == rd_ptr;  // only committed frames are visible
  assign fill_level = wr_ptr - rd_ptr;

  assign mem_we = chk_tvalid & ~drop_frame & ~full_cur;
  assign rd_en  = ~empty & (dn_tready | ~dn_tvalid);

  // bad tuser, overflow now, or overflow earlier in the frame
  assign frame_dropped = chk_tvalid & chk_tlast & (drop_frame | full_cur | chk_tuser);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      wr_ptr_cur <= '0;
      drop_frame <= 1'b0;
    end else if (chk_tvalid) begin
      if (mem_we) begin
        wr_ptr_cur <= wr_ptr_cur + 1'b1;
        if (chk_tlast) begin
          if (chk_tuser) begin
            wr_ptr_cur <= wr_ptr;  // rollback
          end else begin
            wr_ptr <= wr_ptr_cur + 1'b1;  // commit
          end
        end
      end else begin
        drop_frame <= ~chk_tlast;
        if (chk_tlast) begin
          wr_ptr_cur <= wr_ptr;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[wr_ptr_cur[ADDR_WIDTH-1:0]] <= {chk_tlast, chk_tdata};
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr    <= '0;
      dn_tvalid <= 1'b0;
    end else begin
      if (dn_tready || !dn_tvalid) begin
        dn_tvalid <= ~empty;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // output register, refilled when empty or taken
  always_ff @(posedge clk) begin
    if (rd_en) begin
      {dn_tlast, dn_tdata} <= mem[rd_ptr[ADDR_WIDTH-1:0]];
    end
  end

  // reader stays within committed data
  rd_behind_commit : assert property (
    @(posedge clk) disable iff (rst)
    fill_level <= 2**ADDR_WIDTH
  );

endmodule

/* hdl/frame_stats.sv */
`timescale 1ns/1ns

module frame_stats (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           frame_sent,
  input  logic                           frame_dropped,
  output logic [frame_pkg::CNT_WIDTH-1:0] frames_out,
  output logic [frame_pkg::CNT_WIDTH-1:0] frames_dropped
);

  // holds at all ones instead of wrapping
  function automatic logic [frame_pkg::CNT_WIDTH-1:0] sat_inc(
    input logic [frame_pkg::CNT_WIDTH-1:0] value
  );
    if (value == '1) begin
      return value;
    end
    return value + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      frames_out     <= '0;
      frames_dropped <= '0;
    end else begin
      if (frame_sent) begin
        frames_out <= sat_inc(frames_out);
      end
      if (frame_dropped) begin
        frames_dropped <= sat_inc(frames_dropped);
      end
    end
  end

  cnt_monotonic : assert property (
    @(posedge clk) disable iff (rst)
    !rst |=> (frames_out >= $past(frames_out)) &&
             (frames_dropped >= $past(frames_dropped))
  );

endmodule

/* hdl/frame_filter_top.sv */
`timescale 1ns/1ns

module frame_filter_top (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [frame_pkg::DATA_WIDTH-1:0] up_tdata,
  input  logic                            up_tvalid,
  output logic                            up_tready,
  input  logic                            up_tlast,
  input  logic                            up_tuser,
  output logic [frame_pkg::DATA_WIDTH-1:0] dn_tdata,
  output logic                            dn_tvalid,
  input  logic                            dn_tready,
  output logic                            dn_tlast,
  output logic [frame_pkg::CNT_WIDTH-1:0]  frames_out,
  output logic [frame_pkg::CNT_WIDTH-1:0]  frames_dropped
);

  logic [frame_pkg::DATA_WIDTH-1:0] chk_tdata;
  logic                             chk_tvalid;
  logic                             chk_tready;
  logic                             chk_tlast;
  logic                             chk_tuser;
  logic                             oversize;
  logic                             frame_dropped;
  logic                             frame_sent;

  assign frame_sent = dn_tvalid & dn_tready & dn_tlast;

  frame_len_check frame_len_check_i (
    .clk        (clk),
    .rst        (rst),
    .up_tdata   (up_tdata),
    .up_tvalid  (up_tvalid),
    .up_tready  (up_tready),
    .up_tlast   (up_tlast),
    .up_tuser   (up_tuser),
    .chk_tdata  (chk_tdata),
    .chk_tvalid (chk_tvalid),
    .chk_tready (chk_tready),
    .chk_tlast  (chk_tlast),
    .chk_tuser  (chk_tuser),
    .oversize   (oversize)
  );

  axis_frame_fifo #(
    .ADDR_WIDTH (frame_pkg::FIFO_ADDR_WIDTH)
  ) axis_frame_fifo_i (
    .clk           (clk),
    .rst           (rst),
    .chk_tdata     (chk_tdata),
    .chk_tvalid    (chk_tvalid),
    .chk_tready    (chk_tready),
    .chk_tlast     (chk_tlast),
    .chk_tuser     (chk_tuser),
    .dn_tdata      (dn_tdata),
    .dn_tvalid     (dn_tvalid),
    .dn_tready     (dn_tready),
    .dn_tlast      (dn_tlast),
    .frame_dropped (frame_dropped)
  );

  frame_stats frame_stats_i (
    .clk            (clk),
    .rst            (rst),
    .frame_sent     (frame_sent),
    .frame_dropped  (frame_dropped),
    .frames_out     (frames_out),
    .frames_dropped (frames_dropped)
  );

  // the FIFO takes every beat, so an oversize frame is dropped on the same edge
  oversize_dropped : assert property (
    @(posedge clk) disable iff (rst)
    oversize |-> frame_dropped
  );

endmodule

/* bench/frame_filter_tb.sv */
`timescale 1ns/1ns

module frame_filter_tb;

  localparam int CLK_PERIOD     = 8;
  localparam logic [31:0] SEED  = 32'd99638;
  localparam int PHASE1_FRAMES  = 40;  // dn_tready held high
  localparam int PHASE2_FRAMES  = 80;  // random back-pressure and long stalls
  localparam int NUM_FRAMES     = PHASE1_FRAMES + PHASE2_FRAMES;
  localparam int STALL_FACTOR   = 4;
  localparam int TIMEOUT_CYCLES = NUM_FRAMES * 60 * STALL_FACTOR;
  localparam int DRAIN_QUIET    = 16;  // well past the frame latency of the pipeline

  logic                             clk = 1'b0;
  logic                             rst = 1'b1;
  logic [frame_pkg::DATA_WIDTH-1:0] up_tdata;
  logic                             up_tvalid;
  logic                             up_tready;
  logic                             up_tlast;
  logic                             up_tuser;
  logic [frame_pkg::DATA_WIDTH-1:0] dn_tdata;
  logic                             dn_tvalid;
  logic                             dn_tready;
  logic                             dn_tlast;
  logic [frame_pkg::CNT_WIDTH-1:0]  frames_out;
  logic [frame_pkg::CNT_WIDTH-1:0]  frames_dropped;

  // model of the frames in send order with the bytes of all frames back to back
  logic [frame_pkg::DATA_WIDTH-1:0] exp_data[$];
  int                               exp_len[$];
  bit                               exp_bad[$];
  logic [frame_pkg::DATA_WIDTH-1:0] out_beats[$];

  int sent_cnt, bad_cnt, out_cnt, overflow_drops;
  int mismatch_cnt, fail_cnt;
  logic [31:0] rng_up, rng_dn;
  bit stall_on;

  always #(CLK_PERIOD / 2) clk = ~clk;

  frame_filter_top frame_filter_top_i (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // upstream driver
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic drive_beat(input logic [frame_pkg::DATA_WIDTH-1:0] data, input logic last,
                            input logic user);
    logic taken;
    up_tdata  = data;
    up_tvalid = 1'b1;
    up_tlast  = last;
    up_tuser  = user;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = up_tready;  // stable until the next edge
      @(posedge clk);
      #1;
    end
  endtask

  task automatic idle_cycles(input int n);
    up_tvalid = 1'b0;
    up_tlast  = 1'b0;
    up_tuser  = 1'b0;
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic send_random_frame();
    logic [frame_pkg::DATA_WIDTH-1:0] beats[$];
    int len;
    int gap;
    int k;
    bit err;
    bit bad;
    rng_up = xorshift(rng_up);
    len = 1 + rng_up % 60;
    rng_up = xorshift(rng_up);
    err = (rng_up % 8) == 0;
    rng_up = xorshift(rng_up);
    gap = rng_up % 6;
    bad = err || len > frame_pkg::MAX_FRAME_LEN;
    for (k = 0; k < len; k++) begin
      rng_up = xorshift(rng_up);
      beats.push_back(rng_up[frame_pkg::DATA_WIDTH-1:0]);
      exp_data.push_back(rng_up[frame_pkg::DATA_WIDTH-1:0]);
    end
    exp_len.push_back(len);
    exp_bad.push_back(bad);
    sent_cnt++;
    if (bad) bad_cnt++;
    for (k = 0; k < len; k++) begin
      drive_beat(beats[k], k == len - 1, err && k == len - 1);
    end
    idle_cycles(gap);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // frame model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic pop_frame(input bit skipped);
    int k;
    if (skipped && !exp_bad[0]) overflow_drops++;  // good frame lost to overflow
    for (k = 0; k < exp_len[0]; k++) exp_data.delete(0);
    exp_len.delete(0);
    exp_bad.delete(0);
  endtask

  task automatic check_out_frame();
    int idx;
    int off;
    int hit;
    int k;
    int n;
    bit same;
    hit = -1;
    off = 0;
    for (idx = 0; idx < exp_len.size() && hit < 0; idx++) begin
      same = exp_len[idx] == out_beats.size();
      for (k = 0; same && k < exp_len[idx]; k++) same = exp_data[off + k] == out_beats[k];
      if (same && !exp_bad[idx]) begin
        hit = idx;
      end else begin
        assert (!same) else begin
          $display("Bad frame of %0d beats was forwarded to the output", exp_len[idx]);
          fail_cnt++;
        end
      end
      off += exp_len[idx];
    end
    // compare against the oldest good frame when nothing matched
    if (hit < 0) begin
      off = 0;
      for (idx = 0; idx < exp_len.size() && hit < 0; idx++) begin
        if (!exp_bad[idx]) hit = idx;
        else off += exp_len[idx];
      end
      if (hit < 0) begin
        $display("Output frame of %0d beats arrived with no good frame queued",
                 out_beats.size());
        fail_cnt++;
        return;
      end
      n = (exp_len[hit] < out_beats.size()) ? exp_len[hit] : out_beats.size();
      for (k = 0; k < n; k++) begin
        assert (out_beats[k] == exp_data[off + k]) else begin
          $display("Mismatch dn_tdata beat %0d: expected 0x%h, got 0x%h",
                   k, exp_data[off + k], out_beats[k]);
          mismatch_cnt++;
        end
      end
      assert (exp_len[hit] == out_beats.size()) else begin
        $display("Mismatch dn_tlast: expected on beat 0x%h, got on beat 0x%h",
                 exp_len[hit] - 1, out_beats.size() - 1);
        mismatch_cnt++;
      end
    end
    for (idx = 0; idx < hit; idx++) pop_frame(1'b1);
    pop_frame(1'b0);
    out_cnt++;
  endtask

  // an output idle for DRAIN_QUIET cycles has nothing left to send
  // and whatever is still in the model was dropped
  task automatic wait_drain();
    int quiet;
    quiet = 0;
    while (quiet < DRAIN_QUIET) begin
      @(posedge clk);
      #1;
      if (dn_tvalid) begin
        quiet = 0;
      end else begin
        quiet++;
      end
    end
    while (exp_len.size() > 0) pop_frame(1'b1);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // processes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    up_tdata  = '0;
    up_tvalid = 1'b0;
    up_tlast  = 1'b0;
    up_tuser  = 1'b0;
    dn_tready = 1'b1;
    stall_on  = 1'b0;
    rng_up    = SEED;
    repeat (10) @(posedge clk);
    #1 rst = 1'b0;
    assert (!dn_tvalid && frames_out == 0 && frames_dropped == 0 && up_tready) else begin
      $display("Outputs not in their reset state after reset");
      fail_cnt++;
    end
    repeat (PHASE1_FRAMES) send_random_frame();
    wait_drain();
    assert (overflow_drops == 0) else begin
      $display("%0d good frames dropped with dn_tready held high", overflow_drops);
      fail_cnt++;
    end
    stall_on = 1'b1;
    repeat (PHASE2_FRAMES) send_random_frame();
    stall_on = 1'b0;
    wait_drain();
    assert (frames_out == out_cnt) else begin
      $display("Mismatch frames_out: expected 0x%h, got 0x%h", out_cnt, frames_out);
      mismatch_cnt++;
    end
    assert (frames_out + frames_dropped == sent_cnt) else begin
      $display("Mismatch frames_out+frames_dropped: expected 0x%h, got 0x%h",
               sent_cnt, frames_out + frames_dropped);
      mismatch_cnt++;
    end
    assert (frames_dropped == bad_cnt + overflow_drops) else begin
      $display("Mismatch frames_dropped: expected 0x%h, got 0x%h",
               bad_cnt + overflow_drops, frames_dropped);
      mismatch_cnt++;
    end
    $display("Summary: %0d mismatches, %0d other errors",
             mismatch_cnt, fail_cnt);
    if (mismatch_cnt + fail_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // downstream back-pressure in phases of ready, random toggling and long stalls
  initial begin
    int left;
    int kind;
    bit stalling;
    left = 0;
    kind = 2;
    rng_dn = ~SEED;
    @(negedge rst);
    forever begin
      @(posedge clk);
      stalling = stall_on;
      #1;
      if (!stalling) begin
        dn_tready = 1'b1;
        left = 0;
      end else begin
        if (left == 0) begin
          rng_dn = xorshift(rng_dn);
          kind = rng_dn % 8;  // 0 is a long stall and 1..3 toggle
          rng_dn = xorshift(rng_dn);
          left = (kind == 0) ? 150 + rng_dn % 200 : 10 + rng_dn % 50;
        end
        left--;
        rng_dn = xorshift(rng_dn);
        dn_tready = (kind == 0) ? 1'b0 : (kind <= 3) ? rng_dn[0] : 1'b1;
      end
    end
  end

  // output monitor sampling mid-cycle where both sides are settled
  initial begin
    logic                             prev_valid;
    logic                             prev_ready;
    logic                             prev_last;
    logic [frame_pkg::DATA_WIDTH-1:0] prev_data;
    prev_valid = 1'b0;
    prev_ready = 1'b1;
    prev_last  = 1'b0;
    prev_data  = '0;
    forever begin
      @(negedge clk);
      if (!rst) begin
        if (prev_valid && !prev_ready) begin
          assert (dn_tvalid) else begin
            $display("dn_tvalid fell before its beat was taken");
            fail_cnt++;
          end
          assert (dn_tdata == prev_data && dn_tlast == prev_last) else begin
            $display("Mismatch dn_tdata under stall: expected 0x%h, got 0x%h",
                     prev_data, dn_tdata);
            mismatch_cnt++;
          end
        end
        if (dn_tvalid && dn_tready) begin
          out_beats.push_back(dn_tdata);
          if (dn_tlast) begin
            check_out_frame();
            out_beats.delete();
          end
        end
        prev_valid = dn_tvalid;
        prev_ready = dn_tready;
        prev_last  = dn_tlast;
        prev_data  = dn_tdata;
      end
    end
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Watchdog timeout after %0d cycles with %0d of %0d frames sent",
             TIMEOUT_CYCLES, sent_cnt, NUM_FRAMES);
    $display("Errors found");
    $finish;
  end

endmodule

/* list.f */
hdl/frame_pkg.sv
hdl/frame_len_check.sv
hdl/axis_frame_fifo.sv
hdl/frame_stats.sv
hdl/frame_filter_top.sv
bench/frame_filter_tb.sv
